//--- common/rv_decode_pkg.sv
package rv_decode_pkg;

    // Data memory is four bytes wide, one enable per lane
    localparam int byte_lanes = 4;

    // Data, address and instruction words
    typedef logic [31:0] word_t;

    // Register file index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // ALU operation, instruction bit 30 on top of funct3
    typedef logic [3:0] alu_op_t;

    // Data memory byte write enables
    typedef logic [byte_lanes-1:0] byte_en_t;

    // Width and size selector of loads and stores, branch condition
    typedef logic [2:0] funct3_t;

    // Major opcodes of the RV32I groups that are decoded
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // Instruction class, cls_none covers every other opcode
    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_op,
        cls_op_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_none
    } instr_class_e;

    // Format of the immediate fed to the second ALU operand
    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_shamt,
        imm_s,
        imm_u
    } imm_fmt_e;

    // Next PC source
    typedef enum logic [1:0] {
        pc_seq = 2'd0,
        pc_rel = 2'd1,
        pc_reg = 2'd2
    } pc_sel_e;

endpackage

//--- src/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl
    import rv_decode_pkg::*;
(
    input  word_t     idata,
    input  logic      alu_zero_sig,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output reg_addr_t raddr3,
    output alu_op_t   alu_opn,
    output logic      is_pc,
    output logic      is_imm,
    output logic      rwe,
    output logic      mux_alu_or_dmem_sig,
    output logic      mux_alu_or_dmem_enable,
    output logic      store_en,
    output funct3_t   funct3,
    output imm_fmt_e  imm_fmt,
    output pc_sel_e   mux_pc_update_sig
);

    instr_class_e cls;
    funct3_t      f3;
    logic         is_shift_imm;

    assign f3     = idata[14:12];
    assign funct3 = f3;

    // SLLI, SRLI and SRAI share funct3 x01
    assign is_shift_imm = (f3[1:0] == 2'b01);

    // Opcode to class, anything unknown is a no-op
    always_comb begin
        case (idata[6:0])
            opc_lui:    cls = cls_lui;
            opc_auipc:  cls = cls_auipc;
            opc_op:     cls = cls_op;
            opc_op_imm: cls = cls_op_imm;
            opc_load:   cls = cls_load;
            opc_store:  cls = cls_store;
            opc_branch: cls = cls_branch;
            opc_jal:    cls = cls_jal;
            opc_jalr:   cls = cls_jalr;
            default:    cls = cls_none;
        endcase
    end

    always_comb begin
        // Defaults describe the no-op
        raddr1                 = '0;
        raddr2                 = '0;
        raddr3                 = '0;
        alu_opn                = '0;
        is_pc                  = 1'b0;
        is_imm                 = 1'b0;
        rwe                    = 1'b0;
        mux_alu_or_dmem_sig    = 1'b0;
        mux_alu_or_dmem_enable = 1'b0;
        store_en               = 1'b0;
        imm_fmt                = imm_none;
        mux_pc_update_sig      = pc_seq;

        case (cls)
            cls_lui, cls_auipc: begin
                // Upper immediate plus x0 or plus PC, ALU adds
                raddr3                 = idata[11:7];
                is_pc                  = (cls == cls_auipc);
                is_imm                 = 1'b1;
                rwe                    = 1'b1;
                mux_alu_or_dmem_sig    = 1'b1;
                mux_alu_or_dmem_enable = 1'b1;
                imm_fmt                = imm_u;
            end
            cls_op: begin
                raddr1                 = idata[19:15];
                raddr2                 = idata[24:20];
                raddr3                 = idata[11:7];
                // Bit 30 splits ADD/SUB and SRL/SRA
                alu_opn                = {idata[30], f3};
                rwe                    = 1'b1;
                mux_alu_or_dmem_sig    = 1'b1;
                mux_alu_or_dmem_enable = 1'b1;
            end
            cls_op_imm: begin
                raddr1                 = idata[19:15];
                raddr3                 = idata[11:7];
                // Only shifts keep bit 30, elsewhere it is immediate data
                alu_opn                = {is_shift_imm & idata[30], f3};
                is_imm                 = 1'b1;
                rwe                    = 1'b1;
                mux_alu_or_dmem_sig    = 1'b1;
                mux_alu_or_dmem_enable = 1'b1;
                imm_fmt                = is_shift_imm ? imm_shamt : imm_i;
            end
            cls_load: begin
                // Address is rs1 plus offset, result from memory
                raddr1                 = idata[19:15];
                raddr3                 = idata[11:7];
                is_imm                 = 1'b1;
                rwe                    = 1'b1;
                mux_alu_or_dmem_enable = 1'b1;
                imm_fmt                = imm_i;
            end
            cls_store: begin
                raddr1   = idata[19:15];
                raddr2   = idata[24:20];
                is_imm   = 1'b1;
                store_en = 1'b1;
                imm_fmt  = imm_s;
            end
            cls_branch: begin
                // ALU evaluates the condition on rs1 and rs2
                raddr1            = idata[19:15];
                raddr2            = idata[24:20];
                alu_opn           = {1'b0, f3};
                mux_pc_update_sig = alu_zero_sig ? pc_rel : pc_seq;
            end
            cls_jal: begin
                // Link value goes back through the PC path
                raddr3            = idata[11:7];
                rwe               = 1'b1;
                mux_pc_update_sig = pc_rel;
            end
            cls_jalr: begin
                // ALU forms rs1 plus offset as the target
                raddr1            = idata[19:15];
                raddr3            = idata[11:7];
                alu_opn           = {1'b0, f3};
                is_imm            = 1'b1;
                rwe               = 1'b1;
                imm_fmt           = imm_i;
                mux_pc_update_sig = pc_reg;
            end
            default: begin
                // No-op, defaults hold
            end
        endcase
    end

endmodule

//--- src/imm_target_gen.sv
`timescale 1ns/1ps

module imm_target_gen
    import rv_decode_pkg::*;
(
    input  word_t    idata,
    input  word_t    iaddr,
    input  word_t    alu_out,
    input  imm_fmt_e imm_fmt,
    output word_t    mux_alu2_in2,
    output word_t    imm_pc_off,
    output word_t    reg_pc_update_val,
    output word_t    pc_from_reg
);

    word_t off_b;
    word_t off_j;

    // Second ALU operand by immediate format
    always_comb begin
        case (imm_fmt)
            // Sign extended bits 31 to 20
            imm_i:     mux_alu2_in2 = {{20{idata[31]}}, idata[31:20]};
            // Shift amount, no sign extension
            imm_shamt: mux_alu2_in2 = {27'b0, idata[24:20]};
            // Store offset split around rd field
            imm_s:     mux_alu2_in2 = {{20{idata[31]}}, idata[31:25], idata[11:7]};
            imm_u:     mux_alu2_in2 = {idata[31:12], 12'b0};
            default:   mux_alu2_in2 = '0;
        endcase
    end

    // Branch offset, halfword aligned
    assign off_b = {
        {19{idata[31]}},
        idata[31],
        idata[7],
        idata[30:25],
        idata[11:8],
        1'b0
    };

    // Jump offset, halfword aligned
    assign off_j = {
        {11{idata[31]}},
        idata[31],
        idata[19:12],
        idata[20],
        idata[30:21],
        1'b0
    };

    // Opcode bit 3 is set only for JAL
    assign imm_pc_off = idata[3] ? off_j : off_b;

    // Return address for JAL and JALR
    assign reg_pc_update_val = iaddr + 32'd4;

    // JALR target with bit 0 forced low
    assign pc_from_reg = {alu_out[31:1], 1'b0};

endmodule

//--- mem_align/load_align.sv
`timescale 1ns/1ps

module load_align
    import rv_decode_pkg::*;
(
    input  word_t      drdata,
    input  logic [1:0] byte_off,
    input  funct3_t    funct3,
    output word_t      load_data
);

    word_t lane;
    logic  unsigned_ld;

    // Move the addressed byte down to lane 0
    // Bytes past the top of the word shift in as zero
    assign lane = drdata >> {byte_off, 3'b000};

    // LBU and LHU have funct3 bit 2 set
    assign unsigned_ld = funct3[2];

    always_comb begin
        case (funct3[1:0])
            // LB and LBU
            2'b00: begin
                if (unsigned_ld) begin
                    load_data = {24'b0, lane[7:0]};
                end else begin
                    load_data = {{24{lane[7]}}, lane[7:0]};
                end
            end
            // LH and LHU
            2'b01: begin
                if (unsigned_ld) begin
                    load_data = {16'b0, lane[15:0]};
                end else begin
                    load_data = {{16{lane[15]}}, lane[15:0]};
                end
            end
            // LW, whole word as read
            default: begin
                load_data = drdata;
            end
        endcase
    end

endmodule

//--- mem_align/store_align.sv
`timescale 1ns/1ps

module store_align
    import rv_decode_pkg::*;
(
    input  word_t      rrdata2,
    input  logic [1:0] byte_off,
    input  funct3_t    funct3,
    input  logic       store_en,
    input  logic       reset,
    output byte_en_t   dwe,
    output word_t      dwdata
);

    byte_en_t lane_en;
    word_t    shifted;

    // rs2 moved up to the addressed lane
    assign shifted = rrdata2 << {byte_off, 3'b000};

    always_comb begin
        lane_en = '0;
        dwdata  = shifted;
        case (funct3)
            // SB, one lane
            3'b000: begin
                lane_en = byte_en_t'(1) << byte_off;
            end
            // SH, two lanes, crossing the word is not supported
            3'b001: begin
                if (byte_off != 2'b11) begin
                    lane_en = byte_en_t'(2'b11) << byte_off;
                end
            end
            // SW, full word
            3'b010: begin
                lane_en = {byte_lanes{1'b1}};
                dwdata  = rrdata2;
            end
            default: begin
                lane_en = '0;
            end
        endcase
    end

    // No memory write outside a store or while reset is asserted
    assign dwe = (store_en && reset) ? lane_en : '0;

endmodule

//--- src/riscv_decode_top.sv
`timescale 1ns/1ps

module riscv_decode_top
    import rv_decode_pkg::*;
(
    input  word_t     idata,
    input  logic      reset,
    input  word_t     rrdata2,
    input  word_t     drdata,
    input  word_t     alu_out,
    input  logic      alu_zero_sig,
    input  word_t     iaddr,
    output word_t     daddr,
    output word_t     dwdata,
    output byte_en_t  dwe,
    output logic      mux_alu_or_dmem_sig,
    output word_t     mux_alu_or_dmem_inp2,
    output logic      is_pc,
    output logic      is_imm,
    output word_t     mux_alu2_in2,
    output reg_addr_t raddr3,
    output alu_op_t   alu_opn,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output logic      rwe,
    output word_t     pc_from_reg,
    output word_t     reg_pc_update_val,
    output logic      mux_alu_or_dmem_enable,
    output pc_sel_e   mux_pc_update_sig,
    output word_t     imm_pc_off
);

    imm_fmt_e imm_fmt;
    logic     store_en;
    funct3_t  funct3;

    // Memory address is the ALU sum for loads and stores
    assign daddr = alu_out;

    decode_ctrl i_decode_ctrl (
        .idata                  (idata),
        .alu_zero_sig           (alu_zero_sig),
        .raddr1                 (raddr1),
        .raddr2                 (raddr2),
        .raddr3                 (raddr3),
        .alu_opn                (alu_opn),
        .is_pc                  (is_pc),
        .is_imm                 (is_imm),
        .rwe                    (rwe),
        .mux_alu_or_dmem_sig    (mux_alu_or_dmem_sig),
        .mux_alu_or_dmem_enable (mux_alu_or_dmem_enable),
        .store_en               (store_en),
        .funct3                 (funct3),
        .imm_fmt                (imm_fmt),
        .mux_pc_update_sig      (mux_pc_update_sig)
    );

    imm_target_gen i_imm_target_gen (
        .idata             (idata),
        .iaddr             (iaddr),
        .alu_out           (alu_out),
        .imm_fmt           (imm_fmt),
        .mux_alu2_in2      (mux_alu2_in2),
        .imm_pc_off        (imm_pc_off),
        .reg_pc_update_val (reg_pc_update_val),
        .pc_from_reg       (pc_from_reg)
    );

    // Lane select comes from the low address bits
    load_align i_load_align (
        .drdata    (drdata),
        .byte_off  (alu_out[1:0]),
        .funct3    (funct3),
        .load_data (mux_alu_or_dmem_inp2)
    );

    store_align i_store_align (
        .rrdata2  (rrdata2),
        .byte_off (alu_out[1:0]),
        .funct3   (funct3),
        .store_en (store_en),
        .reset    (reset),
        .dwe      (dwe),
        .dwdata   (dwdata)
    );

endmodule

//--- bench/riscv_decode_asserts.sv
`timescale 1ns/1ps

// Decoder checker bound into riscv_decode_top and clocked by the bench clock
module riscv_decode_asserts
    import rv_decode_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      alu_zero_sig,
    input word_t     idata,
    input word_t     rrdata2,
    input word_t     drdata,
    input word_t     alu_out,
    input word_t     iaddr,
    input word_t     daddr,
    input word_t     dwdata,
    input byte_en_t  dwe,
    input logic      mux_alu_or_dmem_sig,
    input logic      mux_alu_or_dmem_enable,
    input word_t     mux_alu_or_dmem_inp2,
    input logic      is_pc,
    input logic      is_imm,
    input logic      rwe,
    input word_t     mux_alu2_in2,
    input reg_addr_t raddr1,
    input reg_addr_t raddr2,
    input reg_addr_t raddr3,
    input alu_op_t   alu_opn,
    input word_t     pc_from_reg,
    input word_t     reg_pc_update_val,
    input pc_sel_e   mux_pc_update_sig,
    input word_t     imm_pc_off
);

    int          fail_count = 0;
    logic [6:0]  opc;
    funct3_t     f3;
    logic [1:0]  boff;
    logic        shift_imm;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    reg_addr_t   exp_rs1;
    reg_addr_t   exp_rs2;
    reg_addr_t   exp_rd;
    alu_op_t     exp_alu;
    word_t       exp_imm;
    logic        exp_is_imm;
    logic        exp_rwe;
    logic        exp_sel;
    logic        exp_en;
    pc_sel_e     exp_pc;
    word_t       exp_ld;
    byte_en_t    exp_dwe;
    word_t       exp_wdata;
    word_t       exp_b_off;
    word_t       exp_j_off;

    assign opc  = idata[6:0];
    assign f3   = idata[14:12];
    assign boff = alu_out[1:0];
    // SLLI uses funct3 001 while SRLI and SRAI use 101
    assign shift_imm = (f3 == 3'b001) || (f3 == 3'b101);

    // Lanes as seen from the low address bits
    assign ld_byte = drdata[8*boff +: 8];
    // Upper byte missing at offset 3
    assign ld_half = (boff == 2'd3) ? {8'h00, drdata[31:24]} : drdata[8*boff +: 16];

    // B offset imm[12|10:5] in 31:25 and imm[4:1|11] in 11:7
    assign exp_b_off = {{20{idata[31]}}, idata[7], idata[30:25], idata[11:8], 1'b0};
    // J offset imm[20|10:1|11|19:12] in 31:12
    assign exp_j_off = {{12{idata[31]}}, idata[19:12], idata[20], idata[30:21], 1'b0};

    // Expected decode with one entry per opcode group
    always_comb begin
        exp_rs1    = '0;
        exp_rs2    = '0;
        exp_rd     = '0;
        exp_alu    = '0;
        exp_imm    = '0;
        exp_is_imm = 1'b0;
        exp_rwe    = 1'b0;
        exp_sel    = 1'b0;
        exp_en     = 1'b0;
        exp_pc     = pc_seq;
        exp_ld     = drdata;
        exp_dwe    = '0;
        exp_wdata  = (f3 == 3'b010) ? rrdata2 : rrdata2 << (8 * boff);
        case (opc)
            opc_lui, opc_auipc: begin
                exp_rd     = idata[11:7];
                exp_imm    = {idata[31:12], 12'h000};
                exp_is_imm = 1'b1;
                exp_rwe    = 1'b1;
                exp_sel    = 1'b1;
                exp_en     = 1'b1;
            end
            opc_op: begin
                exp_rs1 = idata[19:15];
                exp_rs2 = idata[24:20];
                exp_rd  = idata[11:7];
                exp_alu = {idata[30], f3};
                exp_rwe = 1'b1;
                exp_sel = 1'b1;
                exp_en  = 1'b1;
            end
            opc_op_imm: begin
                exp_rs1    = idata[19:15];
                exp_rd     = idata[11:7];
                exp_alu    = {shift_imm & idata[30], f3};
                exp_imm    = shift_imm ? {27'd0, idata[24:20]} : {{20{idata[31]}}, idata[31:20]};
                exp_is_imm = 1'b1;
                exp_rwe    = 1'b1;
                exp_sel    = 1'b1;
                exp_en     = 1'b1;
            end
            opc_load: begin
                exp_rs1    = idata[19:15];
                exp_rd     = idata[11:7];
                exp_imm    = {{20{idata[31]}}, idata[31:20]};
                exp_is_imm = 1'b1;
                exp_rwe    = 1'b1;
                exp_en     = 1'b1;
                case (f3)
                    3'b000:  exp_ld = {{24{ld_byte[7]}}, ld_byte};
                    3'b100:  exp_ld = {24'd0, ld_byte};
                    3'b001:  exp_ld = {{16{ld_half[15]}}, ld_half};
                    3'b101:  exp_ld = {16'd0, ld_half};
                    default: exp_ld = drdata;
                endcase
            end
            opc_store: begin
                exp_rs1    = idata[19:15];
                exp_rs2    = idata[24:20];
                exp_imm    = {{20{idata[31]}}, idata[31:25], idata[11:7]};
                exp_is_imm = 1'b1;
                // Lane table applies only while reset is high
                if (reset) begin
                    case (f3)
                        3'b000:  exp_dwe = 4'b0001 << boff;
                        3'b001:  exp_dwe = (boff == 2'd3) ? 4'b0000 : 4'b0011 << boff;
                        3'b010:  exp_dwe = 4'b1111;
                        default: exp_dwe = 4'b0000;
                    endcase
                end
            end
            opc_branch: begin
                exp_rs1 = idata[19:15];
                exp_rs2 = idata[24:20];
                exp_pc  = alu_zero_sig ? pc_rel : pc_seq;
            end
            opc_jal: begin
                exp_rd  = idata[11:7];
                exp_rwe = 1'b1;
                exp_pc  = pc_rel;
            end
            opc_jalr: begin
                exp_rs1    = idata[19:15];
                exp_rd     = idata[11:7];
                exp_imm    = {{20{idata[31]}}, idata[31:20]};
                exp_is_imm = 1'b1;
                exp_rwe    = 1'b1;
                exp_pc     = pc_reg;
            end
            default: begin
                // Unknown opcode leaves everything at zero
            end
        endcase
    end

    // Error line and failure count for one failing check
    task automatic record_failure(input string name, input word_t exp, input word_t got);
        $error("CHECK FAILED %s exp %h got %h", name, exp, got);
        fail_count++;
    endtask

    a_raddr1: assert property (@(posedge clk) raddr1 == exp_rs1)
        else record_failure("raddr1", $sampled(exp_rs1), $sampled(raddr1));
    a_raddr2: assert property (@(posedge clk) raddr2 == exp_rs2)
        else record_failure("raddr2", $sampled(exp_rs2), $sampled(raddr2));
    a_raddr3: assert property (@(posedge clk) raddr3 == exp_rd)
        else record_failure("raddr3", $sampled(exp_rd), $sampled(raddr3));
    // Bit 30 rule only matters for the ALU groups
    a_alu_opn: assert property (@(posedge clk)
        (opc == opc_op || opc == opc_op_imm) |-> alu_opn == exp_alu)
        else record_failure("alu_opn", $sampled(exp_alu), $sampled(alu_opn));
    a_imm: assert property (@(posedge clk) mux_alu2_in2 == exp_imm)
        else record_failure("mux_alu2_in2", $sampled(exp_imm), $sampled(mux_alu2_in2));
    a_is_imm: assert property (@(posedge clk) is_imm == exp_is_imm)
        else record_failure("is_imm", $sampled(exp_is_imm), $sampled(is_imm));
    a_is_pc: assert property (@(posedge clk) is_pc == (opc == opc_auipc))
        else record_failure("is_pc", $sampled(opc == opc_auipc), $sampled(is_pc));
    a_rwe: assert property (@(posedge clk) rwe == exp_rwe)
        else record_failure("rwe", $sampled(exp_rwe), $sampled(rwe));
    a_wb_sel: assert property (@(posedge clk) mux_alu_or_dmem_sig == exp_sel)
        else record_failure("mux_alu_or_dmem_sig", $sampled(exp_sel),
            $sampled(mux_alu_or_dmem_sig));
    // Low for jumps since the link value takes the PC path
    a_wb_en: assert property (@(posedge clk) mux_alu_or_dmem_enable == exp_en)
        else record_failure("mux_alu_or_dmem_enable", $sampled(exp_en),
            $sampled(mux_alu_or_dmem_enable));
    a_load: assert property (@(posedge clk)
        (opc == opc_load) |-> mux_alu_or_dmem_inp2 == exp_ld)
        else record_failure("mux_alu_or_dmem_inp2", $sampled(exp_ld),
            $sampled(mux_alu_or_dmem_inp2));
    a_daddr: assert property (@(posedge clk) daddr == alu_out)
        else record_failure("daddr", $sampled(alu_out), $sampled(daddr));
    a_dwe: assert property (@(posedge clk) dwe == exp_dwe)
        else record_failure("dwe", $sampled(exp_dwe), $sampled(dwe));
    a_dwdata: assert property (@(posedge clk) (opc == opc_store) |-> dwdata == exp_wdata)
        else record_failure("dwdata", $sampled(exp_wdata), $sampled(dwdata));
    a_pc_sel: assert property (@(posedge clk) mux_pc_update_sig == exp_pc)
        else record_failure("mux_pc_update_sig", $sampled(exp_pc), $sampled(mux_pc_update_sig));
    a_b_off: assert property (@(posedge clk) (opc == opc_branch) |-> imm_pc_off == exp_b_off)
        else record_failure("imm_pc_off", $sampled(exp_b_off), $sampled(imm_pc_off));
    a_j_off: assert property (@(posedge clk) (opc == opc_jal) |-> imm_pc_off == exp_j_off)
        else record_failure("imm_pc_off", $sampled(exp_j_off), $sampled(imm_pc_off));
    a_link: assert property (@(posedge clk)
        (opc == opc_jal || opc == opc_jalr) |-> reg_pc_update_val == iaddr + 32'd4)
        else record_failure("reg_pc_update_val", $sampled(iaddr + 32'd4),
            $sampled(reg_pc_update_val));
    a_jalr_tgt: assert property (@(posedge clk)
        (opc == opc_jalr) |-> pc_from_reg == (alu_out & 32'hffff_fffe))
        else record_failure("pc_from_reg", $sampled(alu_out & 32'hffff_fffe),
            $sampled(pc_from_reg));

endmodule

//--- bench/riscv_decode_tb.sv
`timescale 1ns/1ps

module riscv_decode_tb
    import rv_decode_pkg::*;
();

    localparam int vec_per_test = 64;
    localparam int reset_cycles = 16;
    // Six tests plus reset need about 400 cycles, doubled with some slack
    localparam int max_cycles   = 2 * (6 * vec_per_test + reset_cycles) + 200;

    // Opcode sets walked by the tests, SYSTEM and FENCE are not decoded
    localparam logic [6:0] alu_opcodes [4] = '{opc_lui, opc_auipc, opc_op, opc_op_imm};
    localparam logic [6:0] jump_opcodes [4] = '{opc_jal, opc_jalr, 7'b1110011, 7'b0001111};
    localparam funct3_t    load_f3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

    logic      clk = 1'b0;
    logic      reset;
    logic      alu_zero_sig;
    word_t     idata;
    word_t     rrdata2;
    word_t     drdata;
    word_t     alu_out;
    word_t     iaddr;
    word_t     daddr;
    word_t     dwdata;
    byte_en_t  dwe;
    logic      mux_alu_or_dmem_sig;
    word_t     mux_alu_or_dmem_inp2;
    logic      is_pc;
    logic      is_imm;
    word_t     mux_alu2_in2;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    reg_addr_t raddr3;
    alu_op_t   alu_opn;
    logic      rwe;
    word_t     pc_from_reg;
    word_t     reg_pc_update_val;
    logic      mux_alu_or_dmem_enable;
    pc_sel_e   mux_pc_update_sig;
    word_t     imm_pc_off;
    integer    seed = 4;
    int        cycle_count = 0;
    int        tests_done = 0;
    int        fails_before = 0;

    // 40 ns period
    always #20 clk = ~clk;

    riscv_decode_top i_riscv_decode_top (.*);

    // Checker sees every DUT port plus the bench clock
    bind riscv_decode_top riscv_decode_asserts i_riscv_decode_asserts (
        .clk (riscv_decode_tb.clk),
        .*
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // Random instruction with opcode and funct3 forced
    function automatic word_t make_instr(input logic [6:0] opcode, input funct3_t f3);
        word_t bits;
        bits = $random(seed);
        return {bits[31:15], f3, bits[11:7], opcode};
    endfunction

    // One vector per rising edge, data words random
    task automatic drive_vector(input word_t instr, input logic [1:0] off, input logic rst);
        word_t addr;
        word_t pc;
        @(posedge clk);
        addr = $random(seed);
        pc   = $random(seed);
        idata        <= instr;
        reset        <= rst;
        rrdata2      <= $random(seed);
        drdata       <= $random(seed);
        alu_out      <= {addr[31:2], off};
        alu_zero_sig <= pc[0];
        iaddr        <= {pc[31:2], 2'b00};
    endtask

    task automatic finish_test(input string name);
        int fails;
        // Last vector is sampled on the next edge, its actions run before the falling edge
        @(posedge clk);
        @(negedge clk);
        fails = i_riscv_decode_top.i_riscv_decode_asserts.fail_count - fails_before;
        fails_before = i_riscv_decode_top.i_riscv_decode_asserts.fail_count;
        tests_done++;
        $display("test %0d %s: %0d vectors, %0d failures", tests_done, name, vec_per_test, fails);
    endtask

    initial begin
        idata        <= '0;
        reset        <= 1'b0;
        rrdata2      <= '0;
        drdata       <= '0;
        alu_out      <= '0;
        alu_zero_sig <= 1'b0;
        iaddr        <= '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b1;

        for (int i = 0; i < vec_per_test; i++) begin
            drive_vector(make_instr(alu_opcodes[i % 4], funct3_t'($random(seed))),
                2'($random(seed)), 1'b1);
        end
        finish_test("alu classes");

        // 5 and 4 are coprime, so every width meets every offset
        for (int i = 0; i < vec_per_test; i++) begin
            drive_vector(make_instr(opc_load, load_f3[i % 5]), i[1:0], 1'b1);
        end
        finish_test("loads");

        for (int i = 0; i < vec_per_test; i++) begin
            drive_vector(make_instr(opc_store, funct3_t'(i % 3)), i[1:0], 1'b1);
        end
        finish_test("stores, reset high");

        for (int i = 0; i < vec_per_test; i++) begin
            drive_vector(make_instr(opc_store, funct3_t'(i % 3)), i[1:0], 1'b0);
        end
        finish_test("stores, reset low");

        for (int i = 0; i < vec_per_test; i++) begin
            drive_vector(make_instr(opc_branch, funct3_t'($random(seed))),
                2'($random(seed)), 1'b1);
        end
        finish_test("branches");

        for (int i = 0; i < vec_per_test; i++) begin
            drive_vector(make_instr(jump_opcodes[i % 4], funct3_t'($random(seed))),
                2'($random(seed)), 1'b1);
        end
        finish_test("jumps and unknown opcodes");

        $display("%0d tests, %0d vectors, %0d failed checks",
            tests_done, tests_done * vec_per_test, fails_before);
        if (fails_before == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- riscv_decode_top.f
common/rv_decode_pkg.sv
src/decode_ctrl.sv
src/imm_target_gen.sv
mem_align/load_align.sv
mem_align/store_align.sv
src/riscv_decode_top.sv
bench/riscv_decode_asserts.sv
bench/riscv_decode_tb.sv

//--- Bender.yml
package:
  name: riscv_decode

sources:
  - common/rv_decode_pkg.sv
  - src/decode_ctrl.sv
  - src/imm_target_gen.sv
  - mem_align/load_align.sv
  - mem_align/store_align.sv
  - src/riscv_decode_top.sv
  - target: test
    files:
      - bench/riscv_decode_asserts.sv
      - bench/riscv_decode_tb.sv
